// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := perf_mon_tb
FILELIST  := perf_mon_top.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard hdl/*.sv) $(wildcard dv/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/perf_mon_checker.sv ====
module perf_mon_checker #(
    parameter int metric_width_p = 8
) (
    input  logic        core_clk_i,
    input  logic        rst_n_i,
    input  logic        slot_awvalid_i,
    input  logic        slot_awready_i,
    input  logic        slot_wvalid_i,
    input  logic        slot_wready_i,
    input  logic [7:0]  slot_wstrb_i,
    input  logic        slot_bvalid_i,
    input  logic        slot_bready_i,
    input  logic        slot_arvalid_i,
    input  logic        slot_arready_i,
    input  logic        slot_rvalid_i,
    input  logic        slot_rready_i,
    input  logic        capture_event_i,
    input  logic        reset_event_i,
    input  logic [15:0] s_axil_awaddr_i,
    input  logic        s_axil_awvalid_i,
    input  logic        s_axil_awready_o,
    input  logic [31:0] s_axil_wdata_i,
    input  logic        s_axil_wvalid_i,
    input  logic        s_axil_wready_o,
    input  logic [1:0]  s_axil_bresp_o,
    input  logic        s_axil_bvalid_o,
    input  logic        s_axil_bready_i,
    input  logic [15:0] s_axil_araddr_i,
    input  logic        s_axil_arvalid_i,
    input  logic        s_axil_arready_o,
    input  logic [31:0] s_axil_rdata_o,
    input  logic [1:0]  s_axil_rresp_o,
    input  logic        s_axil_rvalid_o,
    input  logic        s_axil_rready_i,
    input  logic        interrupt_o,
    output int          error_count_o,
    output int          check_count_o
);

    localparam int wrap_lp = 1 << metric_width_p;

    int live [6];
    int samp [6];
    logic [63:0] glob;
    logic [63:0] gsamp;
    logic [1:0] ctrl;
    logic [5:0] status;
    logic [31:0] rdata_exp;
    logic [1:0] rresp_exp;
    logic [1:0] bresp_exp;
    logic rst_q;

    task automatic compare(input string sig, input logic [63:0] exp, input logic [63:0] act);
        check_count_o++;
        if (exp !== act) begin
            error_count_o++;
            $display("** Error %s: expected 0x%0h, actual 0x%0h", sig, exp, act);
        end
    endtask

    // expected read data from the register map.
    task automatic expect_read(input logic [15:0] addr, output logic [31:0] d,
                               output logic [1:0] r);
        d = '0;
        r = 2'b00;
        case (addr)
            16'h0000: d = 32'(ctrl);
            16'h0004: d = 32'(status);
            16'h0008: d = glob_word(0);
            16'h000c: d = glob_word(1);
            16'h0010, 16'h0014, 16'h0018, 16'h001c, 16'h0020, 16'h0024:
                d = 32'(samp[(addr - 16'h0010) >> 2]);
            default: r = 2'b10;
        endcase
    endtask

    function automatic logic [31:0] glob_word(input int hi);
        return hi != 0 ? gsamp[63:32] : gsamp[31:0];
    endfunction

    always @(posedge core_clk_i) begin
        int inc [6];
        int sum;
        int bytes;
        rst_q <= rst_n_i;
        if (!rst_n_i) begin
            live = '{default: 0};
            samp = '{default: 0};
            glob = '0;
            gsamp = '0;
            ctrl = '0;
            status = '0;
            error_count_o = 0;
            check_count_o = 0;
        end else begin
            if (!rst_q) begin // first edge out of reset.
                compare("s_axil_awready_o", 0, 64'(s_axil_awready_o));
                compare("s_axil_wready_o", 0, 64'(s_axil_wready_o));
                compare("s_axil_arready_o", 0, 64'(s_axil_arready_o));
                compare("s_axil_bvalid_o", 0, 64'(s_axil_bvalid_o));
                compare("s_axil_rvalid_o", 0, 64'(s_axil_rvalid_o));
                compare("interrupt_o", 0, 64'(interrupt_o));
            end
            if (s_axil_rvalid_o && s_axil_rready_i) begin
                compare("s_axil_rdata_o", 64'(rdata_exp), 64'(s_axil_rdata_o));
                compare("s_axil_rresp_o", 64'(rresp_exp), 64'(s_axil_rresp_o));
                compare("interrupt_o", 64'(ctrl[1] & (|status)), 64'(interrupt_o));
            end
            if (s_axil_bvalid_o && s_axil_bready_i) begin
                compare("s_axil_bresp_o", 64'(bresp_exp), 64'(s_axil_bresp_o));
            end
            if (s_axil_arvalid_i && s_axil_arready_o) begin
                expect_read(s_axil_araddr_i, rdata_exp, rresp_exp);
            end
            bytes = 0;
            for (int b = 0; b < 8; b++) begin
                bytes += int'(slot_wstrb_i[b]);
            end
            inc[0] = int'(slot_awvalid_i & slot_awready_i);
            inc[1] = int'(slot_arvalid_i & slot_arready_i);
            inc[2] = int'(slot_wvalid_i & slot_wready_i);
            inc[3] = int'(slot_rvalid_i & slot_rready_i);
            inc[4] = (slot_wvalid_i & slot_wready_i) ? bytes : 0;
            inc[5] = int'(slot_bvalid_i & slot_bready_i);
            for (int i = 0; i < 6; i++) begin
                if (ctrl[0]) begin
                    sum = live[i] + inc[i];
                    if (sum >= wrap_lp) begin
                        status[i] = 1'b1; // wrap is sticky.
                    end
                    live[i] = sum % wrap_lp;
                end
            end
            if (capture_event_i) begin
                samp = live;
                gsamp = glob + 64'(ctrl[0]);
            end
            if (capture_event_i || reset_event_i) begin
                live = '{default: 0};
                glob = '0;
            end else begin
                glob = glob + 64'(ctrl[0]);
            end
            if (s_axil_awvalid_i && s_axil_awready_o && s_axil_wvalid_i && s_axil_wready_o) begin
                expect_read(s_axil_awaddr_i, rdata_exp, bresp_exp);
                if (s_axil_awaddr_i == 16'h0000) begin
                    ctrl = s_axil_wdata_i[1:0];
                end else if (s_axil_awaddr_i == 16'h0004) begin
                    status = status & ~s_axil_wdata_i[5:0];
                end
            end
        end
    end

endmodule

// ==== dv/perf_mon_tb.sv ====
module perf_mon_tb;

    localparam int test_cycles = 60 + 260 + 200 + 260 + 440 + 40;
    localparam int timeout_cycles = 2 * test_cycles;

    logic core_clk_i;
    logic rst_n_i;
    logic slot_awvalid_i, slot_awready_i, slot_wvalid_i, slot_wready_i;
    logic [7:0] slot_wstrb_i;
    logic slot_bvalid_i, slot_bready_i, slot_arvalid_i, slot_arready_i;
    logic slot_rvalid_i, slot_rready_i;
    logic capture_event_i, reset_event_i;
    logic [15:0] s_axil_awaddr_i, s_axil_araddr_i;
    logic [31:0] s_axil_wdata_i, s_axil_rdata_o;
    logic [3:0] s_axil_wstrb_i;
    logic s_axil_awvalid_i, s_axil_awready_o, s_axil_wvalid_i, s_axil_wready_o;
    logic [1:0] s_axil_bresp_o, s_axil_rresp_o;
    logic s_axil_bvalid_o, s_axil_bready_i, s_axil_arvalid_i, s_axil_arready_o;
    logic s_axil_rvalid_o, s_axil_rready_i, interrupt_o;
    int error_count, check_count;
    logic [31:0] lcg_state = 32'h1909_bb81;
    int cycle_count = 0;
    int tests_run = 0;
    int tests_bad = 0;
    int err_mark = 0;
    int direct_errors = 0;

    perf_mon_top #(.metric_width_p(8), .data_width_p(64)) dut (.*);

    perf_mon_checker #(.metric_width_p(8)) chk (
        .*,
        .error_count_o(error_count),
        .check_count_o(check_count)
    );

    initial begin
        core_clk_i = 1'b0;
        forever #2 core_clk_i = ~core_clk_i;
    end

    always @(posedge core_clk_i) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic slot_idle();
        {slot_awvalid_i, slot_awready_i, slot_wvalid_i, slot_wready_i} = '0;
        {slot_bvalid_i, slot_bready_i, slot_arvalid_i, slot_arready_i} = '0;
        {slot_rvalid_i, slot_rready_i} = '0;
        slot_wstrb_i = '0;
    endtask

    // random slot levels for n cycles, then three idle cycles.
    task automatic run_traffic(input int n);
        repeat (n) begin
            @(posedge core_clk_i);
            #1;
            lcg_state = lcg_next(lcg_state);
            {slot_awvalid_i, slot_awready_i, slot_wvalid_i, slot_wready_i} = lcg_state[31:28];
            {slot_bvalid_i, slot_bready_i, slot_arvalid_i, slot_arready_i} = lcg_state[27:24];
            {slot_rvalid_i, slot_rready_i} = lcg_state[23:22];
            slot_wstrb_i = lcg_state[21:14];
        end
        @(posedge core_clk_i);
        #1;
        slot_idle();
        repeat (3) @(posedge core_clk_i);
    endtask

    task automatic pulse_event(input logic capture);
        @(posedge core_clk_i);
        #1;
        capture_event_i = capture;
        reset_event_i = !capture;
        @(posedge core_clk_i);
        #1;
        capture_event_i = 1'b0;
        reset_event_i = 1'b0;
    endtask

    task automatic axil_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge core_clk_i);
        #1;
        s_axil_awaddr_i = addr;
        s_axil_wdata_i = data;
        s_axil_awvalid_i = 1'b1;
        s_axil_wvalid_i = 1'b1;
        do @(posedge core_clk_i); while (!s_axil_awready_o);
        #1;
        s_axil_awvalid_i = 1'b0;
        s_axil_wvalid_i = 1'b0;
        do @(posedge core_clk_i); while (!s_axil_bvalid_o); // bready is held high.
    endtask

    task automatic axil_read(input logic [15:0] addr);
        @(posedge core_clk_i);
        #1;
        s_axil_araddr_i = addr;
        s_axil_arvalid_i = 1'b1;
        do @(posedge core_clk_i); while (!s_axil_arready_o);
        #1;
        s_axil_arvalid_i = 1'b0;
        do @(posedge core_clk_i); while (!s_axil_rvalid_o);
    endtask

    task automatic read_all_regs();
        for (int a = 0; a <= 'h24; a += 4) begin
            axil_read(16'(a));
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = error_count + direct_errors - err_mark;
        tests_run++;
        if (n > 0) begin
            tests_bad++;
        end
        $display("test %0d %s: %0d mismatches", tests_run, name, n);
        err_mark = error_count + direct_errors;
    endtask

    initial begin
        rst_n_i = 1'b0;
        slot_idle();
        capture_event_i = 1'b0;
        reset_event_i = 1'b0;
        s_axil_awaddr_i = '0;
        s_axil_araddr_i = '0;
        s_axil_wdata_i = '0;
        s_axil_wstrb_i = 4'hf;
        {s_axil_awvalid_i, s_axil_wvalid_i, s_axil_arvalid_i} = '0;
        s_axil_bready_i = 1'b1;
        s_axil_rready_i = 1'b1;
        repeat (4) @(posedge core_clk_i);
        #1;
        rst_n_i = 1'b1;
        read_all_regs();
        end_test("reset values");
        axil_write(16'h0000, 32'h1);
        run_traffic(200);
        pulse_event(1'b1);
        read_all_regs();
        end_test("counting enabled");
        axil_write(16'h0000, 32'h0);
        pulse_event(1'b1);
        run_traffic(100);
        pulse_event(1'b1);
        read_all_regs();
        end_test("counting disabled");
        axil_write(16'h0000, 32'h1);
        run_traffic(60);
        pulse_event(1'b0);
        run_traffic(60);
        pulse_event(1'b1);
        read_all_regs();
        pulse_event(1'b1);
        read_all_regs();
        end_test("reset event");
        axil_write(16'h0004, 32'h3f);
        run_traffic(360);
        axil_read(16'h0004);
        axil_write(16'h0000, 32'h3);
        repeat (3) @(posedge core_clk_i);
        if (interrupt_o !== 1'b1) begin
            $display("** Error interrupt_o: expected 0x1, actual 0x%0h", interrupt_o);
            direct_errors++;
        end
        axil_read(16'h0004);
        axil_write(16'h0004, 32'h3f);
        repeat (3) @(posedge core_clk_i);
        axil_read(16'h0004);
        end_test("overflow interrupt");
        axil_read(16'h0030);
        axil_write(16'h0010, 32'hff);
        axil_read(16'h0010);
        end_test("bad address and read-only write");
        $display("%0d tests, %0d with mismatches, %0d checks, %0d errors",
                 tests_run, tests_bad, check_count, error_count + direct_errors);
        if (error_count + direct_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== hdl/axil_regs.sv ====
module axil_regs #(
    parameter int metric_width_p = 32
) (
    input  logic                                                     core_clk_i,
    input  logic                                                     rst_n_i,
    input  logic [axil_regs_pkg::lite_addr_width-1:0]                s_axil_awaddr_i,
    input  logic                                                     s_axil_awvalid_i,
    output logic                                                     s_axil_awready_o,
    input  logic [axil_regs_pkg::lite_data_width-1:0]                s_axil_wdata_i,
    input  logic [axil_regs_pkg::lite_data_width/8-1:0]              s_axil_wstrb_i,
    input  logic                                                     s_axil_wvalid_i,
    output logic                                                     s_axil_wready_o,
    output logic [1:0]                                               s_axil_bresp_o,
    output logic                                                     s_axil_bvalid_o,
    input  logic                                                     s_axil_bready_i,
    input  logic [axil_regs_pkg::lite_addr_width-1:0]                s_axil_araddr_i,
    input  logic                                                     s_axil_arvalid_i,
    output logic                                                     s_axil_arready_o,
    output logic [axil_regs_pkg::lite_data_width-1:0]                s_axil_rdata_o,
    output logic [1:0]                                               s_axil_rresp_o,
    output logic                                                     s_axil_rvalid_o,
    input  logic                                                     s_axil_rready_i,
    input  logic [perf_mon_pkg::num_metrics-1:0][metric_width_p-1:0] sample_i,
    input  logic [perf_mon_pkg::global_count_width-1:0]              global_sample_i,
    input  logic [perf_mon_pkg::num_metrics-1:0]                     overflow_i,
    output logic                                                     count_en_o,
    output logic                                                     interrupt_o
);

    localparam int dw_lp = axil_regs_pkg::lite_data_width;

    typedef logic [dw_lp-1:0] word_t;

    axil_regs_pkg::lite_state_e state_q;
    logic [1:0] ctrl_q; // bit0 count enable, bit1 irq enable.
    logic [perf_mon_pkg::num_metrics-1:0] status_q;
    logic [perf_mon_pkg::num_metrics-1:0] status_clr;
    logic wr_fire;
    logic rd_fire;
    logic ctrl_we;
    axil_regs_pkg::resp_e wr_resp;
    axil_regs_pkg::resp_e rd_resp;
    word_t rd_data;

    assign wr_fire = s_axil_awvalid_i & s_axil_awready_o & s_axil_wvalid_i & s_axil_wready_o;
    assign rd_fire = s_axil_arvalid_i & s_axil_arready_o;
    assign count_en_o = ctrl_q[0];

    // write decode.
    always_comb begin
        wr_resp = axil_regs_pkg::resp_okay;
        ctrl_we = 1'b0;
        status_clr = '0;
        case (axil_regs_pkg::reg_addr_e'(s_axil_awaddr_i))
            axil_regs_pkg::reg_ctrl:
                ctrl_we = wr_fire & s_axil_wstrb_i[0];
            axil_regs_pkg::reg_irq_status: begin
                if (wr_fire && s_axil_wstrb_i[0]) begin
                    status_clr = s_axil_wdata_i[perf_mon_pkg::num_metrics-1:0];
                end
            end
            axil_regs_pkg::reg_global_lo, axil_regs_pkg::reg_global_hi,
            axil_regs_pkg::reg_sample_0, axil_regs_pkg::reg_sample_1,
            axil_regs_pkg::reg_sample_2, axil_regs_pkg::reg_sample_3,
            axil_regs_pkg::reg_sample_4, axil_regs_pkg::reg_sample_5:
                wr_resp = axil_regs_pkg::resp_okay; // read only, data dropped.
            default:
                wr_resp = axil_regs_pkg::resp_slverr;
        endcase
    end

    // read mux.
    always_comb begin
        rd_data = '0;
        rd_resp = axil_regs_pkg::resp_okay;
        case (axil_regs_pkg::reg_addr_e'(s_axil_araddr_i))
            axil_regs_pkg::reg_ctrl:       rd_data = word_t'(ctrl_q);
            axil_regs_pkg::reg_irq_status: rd_data = word_t'(status_q);
            axil_regs_pkg::reg_global_lo:  rd_data = global_sample_i[dw_lp-1:0];
            axil_regs_pkg::reg_global_hi:  rd_data = global_sample_i[2*dw_lp-1:dw_lp];
            axil_regs_pkg::reg_sample_0:   rd_data = word_t'(sample_i[0]);
            axil_regs_pkg::reg_sample_1:   rd_data = word_t'(sample_i[1]);
            axil_regs_pkg::reg_sample_2:   rd_data = word_t'(sample_i[2]);
            axil_regs_pkg::reg_sample_3:   rd_data = word_t'(sample_i[3]);
            axil_regs_pkg::reg_sample_4:   rd_data = word_t'(sample_i[4]);
            axil_regs_pkg::reg_sample_5:   rd_data = word_t'(sample_i[5]);
            default:                       rd_resp = axil_regs_pkg::resp_slverr;
        endcase
    end

    always_ff @(posedge core_clk_i) begin
        if (!rst_n_i) begin
            state_q          <= axil_regs_pkg::lite_idle;
            s_axil_awready_o <= 1'b0;
            s_axil_wready_o  <= 1'b0;
            s_axil_arready_o <= 1'b0;
            s_axil_bvalid_o  <= 1'b0;
            s_axil_rvalid_o  <= 1'b0;
        end else begin
            s_axil_awready_o <= 1'b0; // readies are single-cycle pulses.
            s_axil_wready_o  <= 1'b0;
            s_axil_arready_o <= 1'b0;
            case (state_q)
                axil_regs_pkg::lite_idle: begin
                    if (wr_fire) begin
                        s_axil_bvalid_o <= 1'b1;
                        state_q         <= axil_regs_pkg::lite_wresp;
                    end else if (rd_fire) begin
                        s_axil_rvalid_o <= 1'b1;
                        state_q         <= axil_regs_pkg::lite_rdata;
                    end else if (s_axil_awvalid_i && s_axil_wvalid_i) begin
                        s_axil_awready_o <= 1'b1; // write wins over read.
                        s_axil_wready_o  <= 1'b1;
                    end else if (s_axil_arvalid_i) begin
                        s_axil_arready_o <= 1'b1;
                    end
                end
                axil_regs_pkg::lite_wresp: begin
                    if (s_axil_bready_i) begin
                        s_axil_bvalid_o <= 1'b0;
                        state_q         <= axil_regs_pkg::lite_idle;
                    end
                end
                axil_regs_pkg::lite_rdata: begin
                    if (s_axil_rready_i) begin
                        s_axil_rvalid_o <= 1'b0;
                        state_q         <= axil_regs_pkg::lite_idle;
                    end
                end
                default: state_q <= axil_regs_pkg::lite_idle;
            endcase
        end
    end

    always_ff @(posedge core_clk_i) begin
        if (wr_fire) begin
            s_axil_bresp_o <= wr_resp;
        end
        if (rd_fire) begin
            s_axil_rdata_o <= rd_data;
            s_axil_rresp_o <= rd_resp;
        end
    end

    always_ff @(posedge core_clk_i) begin
        if (!rst_n_i) begin
            ctrl_q      <= '0;
            status_q    <= '0;
            interrupt_o <= 1'b0;
        end else begin
            if (ctrl_we) begin
                ctrl_q <= s_axil_wdata_i[1:0];
            end
            status_q    <= (status_q & ~status_clr) | overflow_i; // a new overflow beats the clear.
            interrupt_o <= ctrl_q[1] & (|status_q);
        end
    end

    rvalid_hold_a: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
        s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o && $stable(s_axil_rdata_o));

    bvalid_hold_a: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
        s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o);

endmodule

// ==== hdl/axil_regs_pkg.sv ====
package axil_regs_pkg;

    localparam int lite_addr_width = 16;
    localparam int lite_data_width = 32;

    // byte addresses of the register map.
    typedef enum logic [lite_addr_width-1:0] {
        reg_ctrl       = 16'h0000, // bit0 count enable, bit1 irq enable.
        reg_irq_status = 16'h0004, // write 1 to clear.
        reg_global_lo  = 16'h0008,
        reg_global_hi  = 16'h000c,
        reg_sample_0   = 16'h0010,
        reg_sample_1   = 16'h0014,
        reg_sample_2   = 16'h0018,
        reg_sample_3   = 16'h001c,
        reg_sample_4   = 16'h0020,
        reg_sample_5   = 16'h0024
    } reg_addr_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_e;

    typedef enum logic [1:0] {
        lite_idle,
        lite_wresp,
        lite_rdata
    } lite_state_e;

endpackage

// ==== hdl/metric_counters.sv ====
module metric_counters #(
    parameter int metric_width_p = 32,
    parameter int bytes_width_p = 4
) (
    input  logic                                                     core_clk_i,
    input  logic                                                     rst_n_i,
    input  logic [perf_mon_pkg::num_metrics-1:0]                     ev_valid_i,
    input  logic [bytes_width_p-1:0]                                 wr_bytes_i,
    input  logic                                                     count_en_i,
    input  logic                                                     capture_event_i,
    input  logic                                                     reset_event_i,
    output logic [perf_mon_pkg::num_metrics-1:0][metric_width_p-1:0] sample_o,
    output logic [perf_mon_pkg::global_count_width-1:0]              global_sample_o,
    output logic [perf_mon_pkg::num_metrics-1:0]                     overflow_o
);

    typedef logic [metric_width_p:0] sum_t; // top bit is the wrap carry.
    typedef logic [perf_mon_pkg::global_count_width-1:0] global_t;

    logic [metric_width_p-1:0] live_q [perf_mon_pkg::num_metrics];
    sum_t sum [perf_mon_pkg::num_metrics];
    global_t global_q;
    global_t global_next;
    logic clear;

    assign clear = capture_event_i | reset_event_i;
    assign global_next = global_q + global_t'(count_en_i);

    always_comb begin
        for (int i = 0; i < perf_mon_pkg::num_metrics; i++) begin
            sum[i] = {1'b0, live_q[i]};
            if (count_en_i) begin
                if (perf_mon_pkg::metric_e'(i) == perf_mon_pkg::metric_wr_bytes) begin
                    if (ev_valid_i[i]) begin
                        sum[i] = sum[i] + sum_t'(wr_bytes_i);
                    end
                end else begin
                    sum[i] = sum[i] + sum_t'(ev_valid_i[i]);
                end
            end
        end
    end

    always_ff @(posedge core_clk_i) begin
        if (!rst_n_i) begin
            live_q          <= '{default: '0};
            sample_o        <= '0;
            overflow_o      <= '0;
            global_q        <= '0;
            global_sample_o <= '0;
        end else begin
            for (int i = 0; i < perf_mon_pkg::num_metrics; i++) begin
                overflow_o[i] <= sum[i][metric_width_p];
                live_q[i]     <= clear ? '0 : sum[i][metric_width_p-1:0];
                if (capture_event_i) begin
                    sample_o[i] <= sum[i][metric_width_p-1:0]; // includes this cycle's event.
                end
            end
            global_q <= clear ? '0 : global_next;
            if (capture_event_i) begin
                global_sample_o <= global_next;
            end
        end
    end

    overflow_needs_en_a: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
        overflow_o != '0 |-> $past(count_en_i));

endmodule

// ==== hdl/perf_mon_pkg.sv ====
package perf_mon_pkg;

    localparam int num_metrics = 6;
    localparam int global_count_width = 64;

    // index of each metric in the event, overflow and sample vectors.
    typedef enum logic [2:0] {
        metric_wr_trans = 3'd0,
        metric_rd_trans = 3'd1,
        metric_wr_beats = 3'd2,
        metric_rd_beats = 3'd3,
        metric_wr_bytes = 3'd4, // counted from wstrb.
        metric_wr_resp  = 3'd5
    } metric_e;

endpackage

// ==== hdl/perf_mon_top.sv ====
module perf_mon_top #(
    parameter int metric_width_p = 32,
    parameter int data_width_p = 64
) (
    input  logic                                      core_clk_i,
    input  logic                                      rst_n_i,
    input  logic                                      slot_awvalid_i,
    input  logic                                      slot_awready_i,
    input  logic                                      slot_wvalid_i,
    input  logic                                      slot_wready_i,
    input  logic [data_width_p/8-1:0]                 slot_wstrb_i,
    input  logic                                      slot_bvalid_i,
    input  logic                                      slot_bready_i,
    input  logic                                      slot_arvalid_i,
    input  logic                                      slot_arready_i,
    input  logic                                      slot_rvalid_i,
    input  logic                                      slot_rready_i,
    input  logic                                      capture_event_i,
    input  logic                                      reset_event_i,
    input  logic [axil_regs_pkg::lite_addr_width-1:0] s_axil_awaddr_i,
    input  logic                                      s_axil_awvalid_i,
    output logic                                      s_axil_awready_o,
    input  logic [axil_regs_pkg::lite_data_width-1:0] s_axil_wdata_i,
    input  logic [axil_regs_pkg::lite_data_width/8-1:0] s_axil_wstrb_i,
    input  logic                                      s_axil_wvalid_i,
    output logic                                      s_axil_wready_o,
    output logic [1:0]                                s_axil_bresp_o,
    output logic                                      s_axil_bvalid_o,
    input  logic                                      s_axil_bready_i,
    input  logic [axil_regs_pkg::lite_addr_width-1:0] s_axil_araddr_i,
    input  logic                                      s_axil_arvalid_i,
    output logic                                      s_axil_arready_o,
    output logic [axil_regs_pkg::lite_data_width-1:0] s_axil_rdata_o,
    output logic [1:0]                                s_axil_rresp_o,
    output logic                                      s_axil_rvalid_o,
    input  logic                                      s_axil_rready_i,
    output logic                                      interrupt_o
);

    localparam int bytes_width_lp = $clog2(data_width_p / 8 + 1); // strobe popcount width.

    logic [perf_mon_pkg::num_metrics-1:0] ev_valid;
    logic [bytes_width_lp-1:0] wr_bytes;
    logic [perf_mon_pkg::num_metrics-1:0][metric_width_p-1:0] sample;
    logic [perf_mon_pkg::global_count_width-1:0] global_sample;
    logic [perf_mon_pkg::num_metrics-1:0] overflow;
    logic count_en;

    slot_event_detect #(
        .data_width_p(data_width_p)
    ) u_detect (
        .core_clk_i    (core_clk_i),
        .rst_n_i       (rst_n_i),
        .slot_awvalid_i(slot_awvalid_i),
        .slot_awready_i(slot_awready_i),
        .slot_wvalid_i (slot_wvalid_i),
        .slot_wready_i (slot_wready_i),
        .slot_wstrb_i  (slot_wstrb_i),
        .slot_bvalid_i (slot_bvalid_i),
        .slot_bready_i (slot_bready_i),
        .slot_arvalid_i(slot_arvalid_i),
        .slot_arready_i(slot_arready_i),
        .slot_rvalid_i (slot_rvalid_i),
        .slot_rready_i (slot_rready_i),
        .ev_valid_o    (ev_valid),
        .wr_bytes_o    (wr_bytes)
    );

    metric_counters #(
        .metric_width_p(metric_width_p),
        .bytes_width_p (bytes_width_lp)
    ) u_counters (
        .core_clk_i     (core_clk_i),
        .rst_n_i        (rst_n_i),
        .ev_valid_i     (ev_valid),
        .wr_bytes_i     (wr_bytes),
        .count_en_i     (count_en),
        .capture_event_i(capture_event_i),
        .reset_event_i  (reset_event_i),
        .sample_o       (sample),
        .global_sample_o(global_sample),
        .overflow_o     (overflow)
    );

    axil_regs #(
        .metric_width_p(metric_width_p)
    ) u_regs (
        .core_clk_i      (core_clk_i),
        .rst_n_i         (rst_n_i),
        .s_axil_awaddr_i (s_axil_awaddr_i),
        .s_axil_awvalid_i(s_axil_awvalid_i),
        .s_axil_awready_o(s_axil_awready_o),
        .s_axil_wdata_i  (s_axil_wdata_i),
        .s_axil_wstrb_i  (s_axil_wstrb_i),
        .s_axil_wvalid_i (s_axil_wvalid_i),
        .s_axil_wready_o (s_axil_wready_o),
        .s_axil_bresp_o  (s_axil_bresp_o),
        .s_axil_bvalid_o (s_axil_bvalid_o),
        .s_axil_bready_i (s_axil_bready_i),
        .s_axil_araddr_i (s_axil_araddr_i),
        .s_axil_arvalid_i(s_axil_arvalid_i),
        .s_axil_arready_o(s_axil_arready_o),
        .s_axil_rdata_o  (s_axil_rdata_o),
        .s_axil_rresp_o  (s_axil_rresp_o),
        .s_axil_rvalid_o (s_axil_rvalid_o),
        .s_axil_rready_i (s_axil_rready_i),
        .sample_i        (sample),
        .global_sample_i (global_sample),
        .overflow_i      (overflow),
        .count_en_o      (count_en),
        .interrupt_o     (interrupt_o)
    );

endmodule

// ==== hdl/slot_event_detect.sv ====
module slot_event_detect #(
    parameter int data_width_p = 64,
    localparam int strb_width_lp = data_width_p / 8,
    localparam int bytes_width_lp = $clog2(strb_width_lp + 1)
) (
    input  logic                                   core_clk_i,
    input  logic                                   rst_n_i,
    input  logic                                   slot_awvalid_i,
    input  logic                                   slot_awready_i,
    input  logic                                   slot_wvalid_i,
    input  logic                                   slot_wready_i,
    input  logic [strb_width_lp-1:0]               slot_wstrb_i,
    input  logic                                   slot_bvalid_i,
    input  logic                                   slot_bready_i,
    input  logic                                   slot_arvalid_i,
    input  logic                                   slot_arready_i,
    input  logic                                   slot_rvalid_i,
    input  logic                                   slot_rready_i,
    output logic [perf_mon_pkg::num_metrics-1:0]   ev_valid_o,
    output logic [bytes_width_lp-1:0]              wr_bytes_o
);

    logic [perf_mon_pkg::num_metrics-1:0] hs;
    logic [bytes_width_lp-1:0] strb_count;

    always_comb begin
        hs = '0;
        hs[perf_mon_pkg::metric_wr_trans] = slot_awvalid_i & slot_awready_i;
        hs[perf_mon_pkg::metric_rd_trans] = slot_arvalid_i & slot_arready_i;
        hs[perf_mon_pkg::metric_wr_beats] = slot_wvalid_i & slot_wready_i;
        hs[perf_mon_pkg::metric_rd_beats] = slot_rvalid_i & slot_rready_i;
        hs[perf_mon_pkg::metric_wr_bytes] = slot_wvalid_i & slot_wready_i;
        hs[perf_mon_pkg::metric_wr_resp]  = slot_bvalid_i & slot_bready_i;
        strb_count = '0;
        for (int i = 0; i < strb_width_lp; i++) begin
            strb_count = strb_count + bytes_width_lp'(slot_wstrb_i[i]);
        end
    end

    always_ff @(posedge core_clk_i) begin
        if (!rst_n_i) begin
            ev_valid_o <= '0;
            wr_bytes_o <= '0;
        end else begin
            ev_valid_o <= hs;
            // byte count only travels with a write beat.
            wr_bytes_o <= hs[perf_mon_pkg::metric_wr_bytes] ? strb_count : '0;
        end
    end

    wr_bytes_idle_a: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
        !ev_valid_o[perf_mon_pkg::metric_wr_bytes] |-> wr_bytes_o == '0);

endmodule

// ==== perf_mon_top.f ====
hdl/perf_mon_pkg.sv
hdl/axil_regs_pkg.sv
hdl/slot_event_detect.sv
hdl/metric_counters.sv
hdl/axil_regs.sv
hdl/perf_mon_top.sv
dv/perf_mon_checker.sv
dv/perf_mon_tb.sv
